// File: pll_defines.svh
`ifndef PLL_DEFINES_SVH
`define PLL_DEFINES_SVH

// Stable xo_clk cycles counted before lock
`define PLL_LOCK_DELAY 3

// Reference clock period in ns
`define PLL_REF_PERIOD_NS 8.0

// Frequency meter window in xo_clk cycles
`define PLL_METER_WINDOW 64

// Width of the edge counter and of freq_count
`define PLL_COUNT_W 16

`endif

// File: pll_pkg.sv
`include "pll_defines.svh"

package pll_pkg;

    // Multiply or divide factor
    typedef logic [7:0] pll_ratio_t;

    typedef logic [`PLL_COUNT_W-1:0] freq_count_t;  // pll_clk edges per window

    typedef enum logic [2:0] {
        PLL_OFF     = 3'd0,  // Not enabled
        PLL_BYPASS  = 3'd1,  // Reference clock passed through
        PLL_LOCKING = 3'd2,  // Lock counter running
        PLL_LOCKED  = 3'd3,
        PLL_FAULT   = 3'd4   // Zero mul or div
    } pll_status_e;

endpackage

// File: pll_cfg_if.sv
`timescale 1ns/1ps

interface pll_cfg_if;

    logic                enable;
    logic                bypass;
    logic                pll_reset;  // Restarts locking
    pll_pkg::pll_ratio_t mul;
    pll_pkg::pll_ratio_t div;

    // Driven from the top-level ports
    modport source (
        output enable,
        output bypass,
        output pll_reset,
        output mul,
        output div
    );

    modport sink (
        input enable,
        input bypass,
        input pll_reset,
        input mul,
        input div
    );

endinterface

// File: clock_generator_model.sv
`timescale 1ns/1ps

module clock_generator_model (
    input  logic enable,
    input  real  period_ns,
    output logic clk_out
);

    real half_ns;  // Half period in use for the current phase

    // Free-running oscillator, period re-read every half cycle
    always begin
        if (enable && period_ns > 0.0) begin
            half_ns = period_ns / 2.0;
            #(half_ns);
            if (enable && period_ns > 0.0) begin
                clk_out = (clk_out == 1'b1) ? 1'b0 : 1'b1;  // Also clears an unknown start
            end else begin
                clk_out = 1'b0;
            end
        end else begin
            clk_out = 1'b0;
            @(enable or period_ns);  // Sleep until restarted
        end
    end

endmodule

// File: pll_model.sv
`timescale 1ns/1ps
`include "pll_defines.svh"

module pll_model (
    input  logic                 xo_clk,
    input  logic                 reset_n,
    pll_cfg_if.sink              cfg,
    output logic                 pll_clk,
    output logic                 pll_locked,
    output logic                 pll_error,
    output pll_pkg::pll_status_e pll_status
);

    localparam int               CNT_W     = $clog2(`PLL_LOCK_DELAY + 2);
    localparam logic [CNT_W-1:0] LOCK_LAST = CNT_W'(`PLL_LOCK_DELAY);

    pll_pkg::pll_ratio_t prev_mul;
    pll_pkg::pll_ratio_t prev_div;
    logic [CNT_W-1:0]    lock_cnt;
    logic                lock_q;      // Registered lock state
    logic                ratio_ok;
    logic                cfg_change;
    logic                hold;        // Change or PLL reset in progress
    logic                lock_ok;
    logic                osc_en;
    logic                osc_clk;
    real                 osc_period;

    assign ratio_ok   = (cfg.mul != '0) && (cfg.div != '0);
    assign cfg_change = (cfg.mul != prev_mul) || (cfg.div != prev_div);
    assign hold       = cfg.pll_reset || cfg_change;
    assign pll_error  = cfg.enable && !ratio_ok;
    assign lock_ok    = cfg.enable && ratio_ok && !hold;
    assign osc_en     = cfg.enable && !cfg.bypass && ratio_ok;

    // Lock falls in the same cycle as a change or a fault
    assign pll_locked = lock_q && lock_ok;

    // Output period is reference period times div over mul
    always_comb begin
        if (ratio_ok) begin
            osc_period = `PLL_REF_PERIOD_NS * real'(cfg.div) / real'(cfg.mul);
        end else begin
            osc_period = 0.0;
        end
    end

    clock_generator_model clk_gen_i (
        .enable    (osc_en),
        .period_ns (osc_period),
        .clk_out   (osc_clk)
    );

    always_ff @(posedge xo_clk or negedge reset_n) begin
        if (!reset_n) begin
            prev_mul <= '0;
            prev_div <= '0;
        end else begin
            prev_mul <= cfg.mul;  // Copy for change detection
            prev_div <= cfg.div;
        end
    end

    // Lock on the (LOCK_DELAY+1)-th stable edge, or next edge in bypass
    always_ff @(posedge xo_clk or negedge reset_n) begin
        if (!reset_n) begin
            lock_q   <= 1'b0;
            lock_cnt <= '0;
        end else if (!lock_ok) begin
            lock_q   <= 1'b0;
            lock_cnt <= '0;
        end else if (cfg.bypass) begin
            lock_q <= 1'b1;
        end else if (!lock_q) begin
            if (lock_cnt == LOCK_LAST) begin
                lock_q <= 1'b1;
            end else begin
                lock_cnt <= lock_cnt + 1'b1;
            end
        end
    end

    // Output clock select
    always_comb begin
        if (!lock_ok) begin
            pll_clk = 1'b0;
        end else if (cfg.bypass) begin
            pll_clk = xo_clk;  // Reference passed straight through
        end else if (pll_locked) begin
            pll_clk = osc_clk;
        end else begin
            pll_clk = 1'b0;
        end
    end

    always_comb begin
        if (!cfg.enable) begin
            pll_status = pll_pkg::PLL_OFF;
        end else if (pll_error) begin
            pll_status = pll_pkg::PLL_FAULT;
        end else if (cfg.bypass) begin
            pll_status = pll_pkg::PLL_BYPASS;
        end else if (pll_locked) begin
            pll_status = pll_pkg::PLL_LOCKED;
        end else begin
            pll_status = pll_pkg::PLL_LOCKING;
        end
    end

endmodule

// File: pll_freq_meter.sv
`timescale 1ns/1ps
`include "pll_defines.svh"

module pll_freq_meter (
    input  logic                 xo_clk,
    input  logic                 reset_n,
    input  logic                 pll_clk,
    output pll_pkg::freq_count_t freq_count,
    output logic                 freq_valid
);

    localparam int               WIN_W    = $clog2(`PLL_METER_WINDOW);
    localparam logic [WIN_W-1:0] WIN_LAST = WIN_W'(`PLL_METER_WINDOW - 1);
    localparam logic [WIN_W-1:0] READ_AT  = WIN_W'(`PLL_METER_WINDOW / 2 - 1);

    pll_pkg::freq_count_t edge_cnt;   // Free-running pll_clk edge count
    pll_pkg::freq_count_t snap;       // Count captured at window end
    pll_pkg::freq_count_t prev_snap;
    logic [WIN_W-1:0]     win_cnt;
    logic                 samp_tgl;   // Flips once per window
    logic [2:0]           tgl_sync;   // Two sync stages plus edge detect

    // pll_clk domain
    always_ff @(posedge pll_clk or negedge reset_n) begin
        if (!reset_n) begin
            edge_cnt <= '0;
            tgl_sync <= '0;
            snap     <= '0;
        end else begin
            edge_cnt <= edge_cnt + 1'b1;
            tgl_sync <= {tgl_sync[1:0], samp_tgl};
            if (tgl_sync[2] != tgl_sync[1]) begin
                snap <= edge_cnt;
            end
        end
    end

    // xo_clk domain window and readout
    // snap has settled by mid window, or stays put when pll_clk is stopped
    always_ff @(posedge xo_clk or negedge reset_n) begin
        if (!reset_n) begin
            win_cnt    <= '0;
            samp_tgl   <= 1'b0;
            prev_snap  <= '0;
            freq_count <= '0;
            freq_valid <= 1'b0;
        end else begin
            freq_valid <= 1'b0;
            if (win_cnt == WIN_LAST) begin
                win_cnt  <= '0;
                samp_tgl <= ~samp_tgl;  // Request a snapshot
            end else begin
                win_cnt <= win_cnt + 1'b1;
            end
            if (win_cnt == READ_AT) begin
                freq_count <= snap - prev_snap;  // Edges in the last window
                prev_snap  <= snap;
                freq_valid <= 1'b1;
            end
        end
    end

endmodule

// File: pll_subsys.sv
`timescale 1ns/1ps

module pll_subsys (
    input  logic                 xo_clk,
    input  logic                 reset_n,
    input  logic                 pll_enable,
    input  logic                 pll_bypass,
    input  logic                 pll_reset,
    input  pll_pkg::pll_ratio_t  pll_mul,
    input  pll_pkg::pll_ratio_t  pll_div,
    output logic                 pll_clk,
    output logic                 pll_locked,
    output logic                 pll_error,
    output pll_pkg::pll_status_e pll_status,
    output pll_pkg::freq_count_t freq_count,
    output logic                 freq_valid
);

    pll_cfg_if cfg_if ();

    // Configuration levels onto the interface
    assign cfg_if.enable    = pll_enable;
    assign cfg_if.bypass    = pll_bypass;
    assign cfg_if.pll_reset = pll_reset;
    assign cfg_if.mul       = pll_mul;
    assign cfg_if.div       = pll_div;

    pll_model pll_model_i (
        .xo_clk     (xo_clk),
        .reset_n    (reset_n),
        .cfg        (cfg_if),
        .pll_clk    (pll_clk),
        .pll_locked (pll_locked),
        .pll_error  (pll_error),
        .pll_status (pll_status)
    );

    // Measures the output clock against the reference
    pll_freq_meter pll_freq_meter_i (
        .xo_clk     (xo_clk),
        .reset_n    (reset_n),
        .pll_clk    (pll_clk),
        .freq_count (freq_count),
        .freq_valid (freq_valid)
    );

endmodule

// File: pll_subsys_checker.sv
`timescale 1ns/1ps

module pll_subsys_checker (
    input logic                 xo_clk,
    input logic                 reset_n,
    input logic                 pll_enable,
    input pll_pkg::pll_ratio_t  pll_mul,
    input logic                 pll_locked,
    input logic                 pll_error,
    input pll_pkg::pll_status_e pll_status,
    input logic                 freq_valid
);

    error_blocks_lock: assert property (@(posedge xo_clk) disable iff (!reset_n)
        pll_error |-> !pll_locked)
        else $error("pll_locked is high while pll_error is set");

    // Lock is combinational on the change, so it is already low at the next edge
    mul_change_drops_lock: assert property (@(posedge xo_clk) disable iff (!reset_n)
        $changed(pll_mul) |-> !pll_locked)
        else $error("pll_locked stayed high after a change of pll_mul");

    valid_one_cycle: assert property (@(posedge xo_clk) disable iff (!reset_n)
        freq_valid |=> !freq_valid)
        else $error("freq_valid lasted more than one cycle");

    locked_status: assert property (@(posedge xo_clk) disable iff (!reset_n)
        pll_locked |-> (pll_status == pll_pkg::PLL_LOCKED || pll_status == pll_pkg::PLL_BYPASS))
        else $error("pll_status does not match a locked PLL");

    off_status: assert property (@(posedge xo_clk) disable iff (!reset_n)
        !pll_enable |-> pll_status == pll_pkg::PLL_OFF)
        else $error("pll_status is not PLL_OFF while disabled");

endmodule

bind pll_subsys pll_subsys_checker pll_subsys_checker_i (
    .xo_clk     (xo_clk),
    .reset_n    (reset_n),
    .pll_enable (pll_enable),
    .pll_mul    (pll_mul),
    .pll_locked (pll_locked),
    .pll_error  (pll_error),
    .pll_status (pll_status),
    .freq_valid (freq_valid)
);

// File: tb_pll_subsys.sv
`timescale 1ns/1ps
`include "pll_defines.svh"

module tb_pll_subsys;

    localparam int TOL       = 2;  // Allowed count error per window
    localparam int READ_SKIP = 3;  // Third reading is the first with a full window after lock

    logic                 xo_clk;
    logic                 reset_n;
    logic                 pll_enable;
    logic                 pll_bypass;
    logic                 pll_reset;
    pll_pkg::pll_ratio_t  pll_mul;
    pll_pkg::pll_ratio_t  pll_div;
    logic                 pll_clk;
    logic                 pll_locked;
    logic                 pll_error;
    pll_pkg::pll_status_e pll_status;
    pll_pkg::freq_count_t freq_count;
    logic                 freq_valid;

    // One table entry per line of the input file
    string t_name[$];
    int    t_en[$];
    int    t_byp[$];
    int    t_mul[$];
    int    t_div[$];
    int    t_lock[$];
    int    t_err[$];
    int    t_cnt[$];
    int    t_act[$];  // 0 none, 1 mul step down, 2 pll_reset pulse

    int    n_checks = 0;
    int    n_errors = 0;
    bit    tests_ready = 1'b0;

    initial xo_clk = 1'b0;
    always #(`PLL_REF_PERIOD_NS / 2.0) xo_clk = ~xo_clk;

    pll_subsys pll_subsys_i (
        .xo_clk     (xo_clk),
        .reset_n    (reset_n),
        .pll_enable (pll_enable),
        .pll_bypass (pll_bypass),
        .pll_reset  (pll_reset),
        .pll_mul    (pll_mul),
        .pll_div    (pll_div),
        .pll_clk    (pll_clk),
        .pll_locked (pll_locked),
        .pll_error  (pll_error),
        .pll_status (pll_status),
        .freq_count (freq_count),
        .freq_valid (freq_valid)
    );

    task automatic check_value(input string test, input string what, input int exp,
                               input int act);
        n_checks++;
        assert (act == exp) else begin
            n_errors++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", test, what, exp, act);
        end
    endtask

    task automatic check_near(input string test, input string what, input int exp,
                              input int act);
        n_checks++;
        assert (act >= exp - TOL && act <= exp + TOL) else begin
            n_errors++;
            $display("MISMATCH %s %s: expected %0d +/- %0d, actual %0d",
                     test, what, exp, TOL, act);
        end
    endtask

    task automatic report_failure(input string msg);
        n_errors++;
        $display("ERROR: %s", msg);
    endtask

    task automatic load_tests();
        int    fd;
        int    fields;
        string line;
        string name;
        int    en;
        int    byp;
        int    r_mul;
        int    r_div;
        int    lock;
        int    err;
        int    cnt;
        int    act;
        fd = $fopen("pll_subsys_input.txt", "r");
        if (fd == 0) begin
            report_failure("could not open pll_subsys_input.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.substr(0, 0) == "#") begin
                continue;  // Blank or comment line
            end
            fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d",
                             name, en, byp, r_mul, r_div, lock, err, cnt, act);
            if (fields != 9) begin
                report_failure({"badly formed line in input file: ", line});
                continue;
            end
            t_name.push_back(name);
            t_en.push_back(en);
            t_byp.push_back(byp);
            t_mul.push_back(r_mul);
            t_div.push_back(r_div);
            t_lock.push_back(lock);
            t_err.push_back(err);
            t_cnt.push_back(cnt);
            t_act.push_back(act);
        end
        $fclose(fd);
        if (t_name.size() == 0) begin
            report_failure("the input file holds no tests");
        end
    endtask

    // One edge registers the new ratio, then bypass locks at once or the counter runs
    function automatic int lock_edges(input int byp);
        return 1 + ((byp != 0) ? 1 : `PLL_LOCK_DELAY + 1);
    endfunction

    function automatic int expect_status(input int en, input int byp, input int err,
                                         input int locked);
        if (en == 0) begin
            return int'(pll_pkg::PLL_OFF);
        end else if (err != 0) begin
            return int'(pll_pkg::PLL_FAULT);
        end else if (byp != 0) begin
            return int'(pll_pkg::PLL_BYPASS);
        end else if (locked != 0) begin
            return int'(pll_pkg::PLL_LOCKED);
        end
        return int'(pll_pkg::PLL_LOCKING);
    endfunction

    // Edge number, counted from the call, at which pll_locked was first seen high
    task automatic watch_lock(input int max_edges, output int first);
        first = 0;
        for (int k = 1; k <= max_edges; k++) begin
            @(posedge xo_clk);
            @(negedge xo_clk);
            if (pll_locked && first == 0) begin
                first = k;
            end
        end
    endtask

    task automatic wait_valid(input int n);
        int seen;
        seen = 0;
        while (seen < n) begin
            @(negedge xo_clk);
            if (freq_valid) begin
                seen++;
            end
        end
    endtask

    task automatic disturb(input int i, input int lat);
        string name;
        int    first;
        @(posedge xo_clk);
        if (t_act[i] == 1) begin
            name = {t_name[i], "_mul_step"};
            pll_mul <= pll_mul - 1'b1;
        end else begin
            name = {t_name[i], "_pll_reset"};
            pll_reset <= 1'b1;
        end
        @(negedge xo_clk);
        check_value(name, "pll_locked after change", 0, int'(pll_locked));
        @(posedge xo_clk);
        pll_reset <= 1'b0;
        watch_lock(lat + 3, first);
        check_value(name, "relock edge", lat, first + 1);  // Change edge not seen by watch_lock
    endtask

    task automatic run_test(input int i);
        string name;
        int    gap;
        int    lat;
        int    first;
        name = t_name[i];
        gap  = 2 + ($urandom % 8);
        @(posedge xo_clk);
        pll_enable <= 1'b0;  // Idle with a zero ratio, so the test ratio is a change
        pll_bypass <= 1'b0;
        pll_reset  <= 1'b0;
        pll_mul    <= '0;
        pll_div    <= '0;
        repeat (gap) @(posedge xo_clk);
        pll_enable <= (t_en[i] != 0);
        pll_bypass <= (t_byp[i] != 0);
        pll_mul    <= pll_pkg::pll_ratio_t'(t_mul[i]);
        pll_div    <= pll_pkg::pll_ratio_t'(t_div[i]);
        lat = lock_edges(t_byp[i]);
        watch_lock(lat + 3, first);
        check_value(name, "lock edge", (t_lock[i] != 0) ? lat : 0, first);
        check_value(name, "pll_error", t_err[i], int'(pll_error));
        check_value(name, "pll_status",
                    expect_status(t_en[i], t_byp[i], t_err[i], t_lock[i]), int'(pll_status));
        wait_valid(READ_SKIP);
        if (t_cnt[i] == 0) begin
            check_value(name, "freq_count", 0, int'(freq_count));
        end else begin
            check_near(name, "freq_count", t_cnt[i], int'(freq_count));
        end
        check_value(name, "pll_locked held", t_lock[i], int'(pll_locked));
        if (t_act[i] != 0) begin
            disturb(i, lat);
        end
    endtask

    initial begin : watchdog
        int limit;
        wait (tests_ready);
        limit = t_name.size() * (3 * `PLL_METER_WINDOW + 32) + 200;  // Cycles for all tests
        repeat (limit) @(posedge xo_clk);
        $display("ERROR: watchdog expired after %0d cycles before the tests finished", limit);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
        $display("Test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h598cb334));
        reset_n    = 1'b0;
        pll_enable = 1'b0;
        pll_bypass = 1'b0;
        pll_reset  = 1'b0;
        pll_mul    = '0;
        pll_div    = '0;
        load_tests();
        tests_ready = 1'b1;
        repeat (4) @(posedge xo_clk);
        reset_n <= 1'b1;
        @(negedge xo_clk);
        check_value("reset", "pll_locked", 0, int'(pll_locked));
        check_value("reset", "pll_clk", 0, int'(pll_clk));
        check_value("reset", "freq_valid", 0, int'(freq_valid));
        check_value("reset", "pll_status", int'(pll_pkg::PLL_OFF), int'(pll_status));
        for (int i = 0; i < t_name.size(); i++) begin
            run_test(i);
        end
        repeat (4) @(posedge xo_clk);
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: pll_subsys_input.txt
# name enable bypass mul div exp_lock exp_error exp_count action
# action: 0 none, 1 mul one lower while locked, 2 pll_reset pulse while locked
off_after_reset 0 0 1 1 0 0 0 0
ratio_1_1 1 0 1 1 1 0 64 0
ratio_2_1 1 0 2 1 1 0 128 1
ratio_3_2 1 0 3 2 1 0 96 2
ratio_4_1 1 0 4 1 1 0 256 1
bypass 1 1 1 1 1 0 64 2
zero_div 1 0 3 0 0 1 0 0
zero_mul 1 0 0 2 0 1 0 0
bypass_zero 1 1 0 0 0 1 0 0
off_with_ratio 0 0 2 1 0 0 0 0

// File: sim.f
+incdir+.
pll_pkg.sv
pll_cfg_if.sv
clock_generator_model.sv
pll_model.sv
pll_freq_meter.sv
pll_subsys.sv
pll_subsys_checker.sv
tb_pll_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pll_subsys
FLIST     ?= sim.f
SEED      ?= 1502393140
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard *.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(OBJ_DIR)/V%: $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) +verilator+seed+$(SEED) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG) || ! grep -q "Test passed" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
